//--- hw/rv_pkg.sv
// ================================================
// rv core package
// widths, opcodes, function codes, instruction
// field layouts and fetch FSM state encodings
// ================================================

`default_nettype none

package rv_pkg;

    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_SW      = 3'b010;

    // funct7 for subtract, all other supported ops use zero
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // fetch FSM states
    localparam logic [1:0] FETCH_IDLE       = 2'd0;
    localparam logic [1:0] FETCH_REQ        = 2'd1;
    localparam logic [1:0] FETCH_WAIT_VALID = 2'd2;
    localparam logic [1:0] FETCH_HOLD       = 2'd3;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // one fetched word seen in each encoding format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
    } instr_t;

endpackage

`default_nettype wire

//--- hw/rv_fetch.sv
// ================================================
// rv fetch unit
// keeps the pc and runs the request/grant/valid
// sequence on the instruction port
// ================================================

`default_nettype none

module rv_fetch (
    input  wire logic           clk_i,
    input  wire logic           reset_i,
    input  wire logic           fetch_enable_i,
    input  wire rv_pkg::addr_t  boot_addr_i,
    input  wire logic           retire_i,
    output logic                instr_req_o,
    output rv_pkg::addr_t       instr_addr_o,
    input  wire logic           instr_gnt_i,
    input  wire logic           instr_rvalid_i,
    input  wire rv_pkg::word_t  instr_rdata_i,
    output logic                instr_valid_o,
    output rv_pkg::instr_t      instr_word_o,
    output logic                busy_o
);

    logic [1:0]    state_q;
    rv_pkg::addr_t pc_q;
    logic          valid_q;
    rv_pkg::word_t word_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= rv_pkg::FETCH_IDLE;
            pc_q    <= boot_addr_i;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                rv_pkg::FETCH_IDLE: begin
                    if (fetch_enable_i) begin
                        state_q <= rv_pkg::FETCH_REQ;
                    end
                end
                rv_pkg::FETCH_REQ: begin
                    // address stays on pc_q until granted
                    if (instr_gnt_i) begin
                        state_q <= rv_pkg::FETCH_WAIT_VALID;
                    end
                end
                rv_pkg::FETCH_WAIT_VALID: begin
                    if (instr_rvalid_i) begin
                        state_q <= rv_pkg::FETCH_HOLD;
                        valid_q <= 1'b1;
                    end
                end
                default: begin
                    // hold the word until execute retires it
                    if (retire_i) begin
                        pc_q    <= pc_q + 32'd4;
                        state_q <= fetch_enable_i ? rv_pkg::FETCH_REQ : rv_pkg::FETCH_IDLE;
                    end
                end
            endcase
        end
    end

    // instruction word latch
    always_ff @(posedge clk_i) begin
        if (state_q == rv_pkg::FETCH_WAIT_VALID && instr_rvalid_i) begin
            word_q <= instr_rdata_i;
        end
    end

    assign instr_req_o   = (state_q == rv_pkg::FETCH_REQ);
    assign instr_addr_o  = pc_q;
    assign instr_valid_o = valid_q;
    assign instr_word_o  = word_q;
    assign busy_o        = (state_q != rv_pkg::FETCH_IDLE);

endmodule

`default_nettype wire

//--- hw/rv_decode.sv
// ================================================
// rv decoder
// turns the fetched word into register indices,
// immediate and execute control
// ================================================

`default_nettype none

module rv_decode (
    input  wire rv_pkg::instr_t  instr_i,
    output rv_pkg::reg_idx_t     rs1_o,
    output rv_pkg::reg_idx_t     rs2_o,
    output rv_pkg::reg_idx_t     rd_o,
    output rv_pkg::word_t        imm_o,
    output rv_pkg::alu_op_t      alu_op_o,
    output logic                 use_imm_o,
    output logic                 reg_write_o,
    output logic                 is_store_o
);

    // register fields sit at the same place in every format
    assign rs1_o = instr_i.r.rs1;
    assign rs2_o = instr_i.r.rs2;
    assign rd_o  = instr_i.r.rd;

    always_comb begin
        imm_o       = '0;
        alu_op_o    = rv_pkg::ALU_ADD;
        use_imm_o   = 1'b0;
        reg_write_o = 1'b0;
        is_store_o  = 1'b0;

        case (instr_i.r.opcode)
            rv_pkg::OPC_OP: begin
                reg_write_o = 1'b1;
                case (instr_i.r.funct3)
                    rv_pkg::F3_ADD_SUB: begin
                        if (instr_i.r.funct7 == rv_pkg::F7_SUB) begin
                            alu_op_o = rv_pkg::ALU_SUB;
                        end else if (instr_i.r.funct7 != 7'b0) begin
                            reg_write_o = 1'b0;
                        end
                    end
                    rv_pkg::F3_XOR: alu_op_o = rv_pkg::ALU_XOR;
                    rv_pkg::F3_OR:  alu_op_o = rv_pkg::ALU_OR;
                    rv_pkg::F3_AND: alu_op_o = rv_pkg::ALU_AND;
                    default:        reg_write_o = 1'b0;
                endcase
                // only sub may carry a nonzero funct7
                if (instr_i.r.funct3 != rv_pkg::F3_ADD_SUB && instr_i.r.funct7 != 7'b0) begin
                    reg_write_o = 1'b0;
                end
            end
            rv_pkg::OPC_OP_IMM: begin
                // addi only
                imm_o       = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                use_imm_o   = 1'b1;
                reg_write_o = (instr_i.i.funct3 == rv_pkg::F3_ADD_SUB);
            end
            rv_pkg::OPC_LUI: begin
                imm_o       = {instr_i.i.imm, instr_i.i.rs1, instr_i.i.funct3, 12'b0};
                alu_op_o    = rv_pkg::ALU_PASS_B;
                use_imm_o   = 1'b1;
                reg_write_o = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                imm_o      = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
                use_imm_o  = 1'b1;
                is_store_o = (instr_i.s.funct3 == rv_pkg::F3_SW);
            end
            default: begin
                // anything else retires as a no-op
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/rv_regfile.sv
// ================================================
// rv register file
// 32 x 32-bit, two async reads, one sync write,
// x0 hard wired to zero
// ================================================

`default_nettype none

module rv_regfile (
    input  wire logic              clk_i,
    input  wire logic              reset_i,
    input  wire rv_pkg::reg_idx_t  raddr_a_i,
    input  wire rv_pkg::reg_idx_t  raddr_b_i,
    output rv_pkg::word_t          rdata_a_o,
    output rv_pkg::word_t          rdata_b_o,
    input  wire logic              we_i,
    input  wire rv_pkg::reg_idx_t  waddr_i,
    input  wire rv_pkg::word_t     wdata_i
);

    rv_pkg::word_t regs_q [32];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- hw/rv_execute.sv
// ================================================
// rv execute stage
// alu, register write back and store requests
// on the data port, retire pulse back to fetch
// ================================================

`default_nettype none

module rv_execute (
    input  wire logic              clk_i,
    input  wire logic              reset_i,
    input  wire logic              instr_valid_i,
    input  wire rv_pkg::alu_op_t   alu_op_i,
    input  wire logic              use_imm_i,
    input  wire rv_pkg::word_t     imm_i,
    input  wire logic              reg_write_i,
    input  wire logic              is_store_i,
    input  wire rv_pkg::reg_idx_t  rd_i,
    input  wire rv_pkg::word_t     op_a_i,
    input  wire rv_pkg::word_t     op_b_i,
    output logic                   rf_we_o,
    output rv_pkg::reg_idx_t       rf_waddr_o,
    output rv_pkg::word_t          rf_wdata_o,
    output logic                   data_req_o,
    output rv_pkg::addr_t          data_addr_o,
    output rv_pkg::word_t          data_wdata_o,
    input  wire logic              data_gnt_i,
    output logic                   retire_o
);

    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    logic          store_q;
    rv_pkg::addr_t store_addr_q;
    rv_pkg::word_t store_data_q;

    assign alu_b = use_imm_i ? imm_i : op_b_i;

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_SUB:    alu_result = op_a_i - alu_b;
            rv_pkg::ALU_AND:    alu_result = op_a_i & alu_b;
            rv_pkg::ALU_OR:     alu_result = op_a_i | alu_b;
            rv_pkg::ALU_XOR:    alu_result = op_a_i ^ alu_b;
            rv_pkg::ALU_PASS_B: alu_result = alu_b;
            default:            alu_result = op_a_i + alu_b;
        endcase
    end

    // write back happens in the valid cycle itself
    assign rf_we_o    = instr_valid_i & reg_write_i;
    assign rf_waddr_o = rd_i;
    assign rf_wdata_o = alu_result;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            store_q <= 1'b0;
        end else if (instr_valid_i && is_store_i) begin
            store_q <= 1'b1;
        end else if (store_q && data_gnt_i) begin
            store_q <= 1'b0;
        end
    end

    // address is rs1 + imm from the alu, data is rs2
    always_ff @(posedge clk_i) begin
        if (instr_valid_i && is_store_i) begin
            store_addr_q <= alu_result;
            store_data_q <= op_b_i;
        end
    end

    assign data_req_o   = store_q;
    assign data_addr_o  = store_addr_q;
    assign data_wdata_o = store_data_q;

    // alu ops and no-ops retire at once, stores on grant
    assign retire_o = (instr_valid_i & ~is_store_i) | (store_q & data_gnt_i);

endmodule

`default_nettype wire

//--- hw/rv_core.sv
// ================================================
// rv core top
// fetch, decode, register file and execute
// ================================================

`default_nettype none

module rv_core (
    input  wire logic           clk_i,
    input  wire logic           reset_i,
    input  wire logic           fetch_enable_i,
    input  wire rv_pkg::addr_t  boot_addr_i,
    output logic                core_busy_o,
    output logic                instr_req_o,
    output rv_pkg::addr_t       instr_addr_o,
    input  wire logic           instr_gnt_i,
    input  wire logic           instr_rvalid_i,
    input  wire rv_pkg::word_t  instr_rdata_i,
    output logic                data_req_o,
    output rv_pkg::addr_t       data_addr_o,
    output rv_pkg::word_t       data_wdata_o,
    input  wire logic           data_gnt_i
);

    logic             instr_valid;
    rv_pkg::instr_t   instr_word;
    logic             retire;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    imm;
    rv_pkg::alu_op_t  alu_op;
    logic             use_imm;
    logic             reg_write;
    logic             is_store;
    rv_pkg::word_t    op_a;
    rv_pkg::word_t    op_b;
    logic             rf_we;
    rv_pkg::reg_idx_t rf_waddr;
    rv_pkg::word_t    rf_wdata;

    rv_fetch u_fetch (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .boot_addr_i    ( boot_addr_i    ),
        .retire_i       ( retire         ),
        .instr_req_o    ( instr_req_o    ),
        .instr_addr_o   ( instr_addr_o   ),
        .instr_gnt_i    ( instr_gnt_i    ),
        .instr_rvalid_i ( instr_rvalid_i ),
        .instr_rdata_i  ( instr_rdata_i  ),
        .instr_valid_o  ( instr_valid    ),
        .instr_word_o   ( instr_word     ),
        .busy_o         ( core_busy_o    )
    );

    rv_decode u_decode (
        .instr_i     ( instr_word ),
        .rs1_o       ( rs1        ),
        .rs2_o       ( rs2        ),
        .rd_o        ( rd         ),
        .imm_o       ( imm        ),
        .alu_op_o    ( alu_op     ),
        .use_imm_o   ( use_imm    ),
        .reg_write_o ( reg_write  ),
        .is_store_o  ( is_store   )
    );

    rv_regfile u_regfile (
        .clk_i     ( clk_i    ),
        .reset_i   ( reset_i  ),
        .raddr_a_i ( rs1      ),
        .raddr_b_i ( rs2      ),
        .rdata_a_o ( op_a     ),
        .rdata_b_o ( op_b     ),
        .we_i      ( rf_we    ),
        .waddr_i   ( rf_waddr ),
        .wdata_i   ( rf_wdata )
    );

    rv_execute u_execute (
        .clk_i         ( clk_i        ),
        .reset_i       ( reset_i      ),
        .instr_valid_i ( instr_valid  ),
        .alu_op_i      ( alu_op       ),
        .use_imm_i     ( use_imm      ),
        .imm_i         ( imm          ),
        .reg_write_i   ( reg_write    ),
        .is_store_i    ( is_store     ),
        .rd_i          ( rd           ),
        .op_a_i        ( op_a         ),
        .op_b_i        ( op_b         ),
        .rf_we_o       ( rf_we        ),
        .rf_waddr_o    ( rf_waddr     ),
        .rf_wdata_o    ( rf_wdata     ),
        .data_req_o    ( data_req_o   ),
        .data_addr_o   ( data_addr_o  ),
        .data_wdata_o  ( data_wdata_o ),
        .data_gnt_i    ( data_gnt_i   ),
        .retire_o      ( retire       )
    );

endmodule

`default_nettype wire

//--- dv/core_tb.sv
// ================================================
// rv core testbench
// random program from an LFSR, instruction and
// data memory responders, reference model checks
// ================================================

`default_nettype none

module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int            NUM_RANDOM     = 200;
    localparam int            NUM_INSTR      = NUM_RANDOM + 32;
    localparam int            PAUSE_AT       = 100;
    localparam int            TIMEOUT_CYCLES = NUM_INSTR * 10;
    localparam rv_pkg::addr_t BOOT_ADDR      = 32'h100;

    logic          clk_i = 1'b0;
    logic          reset_i;
    logic          fetch_enable_i;
    rv_pkg::addr_t boot_addr_i;
    logic          core_busy_o;
    logic          instr_req_o;
    rv_pkg::addr_t instr_addr_o;
    logic          instr_gnt_i = 1'b0;
    logic          instr_rvalid_i = 1'b0;
    rv_pkg::word_t instr_rdata_i = '0;
    logic          data_req_o;
    rv_pkg::addr_t data_addr_o;
    rv_pkg::word_t data_wdata_o;
    logic          data_gnt_i = 1'b0;

    logic [31:0]   lfsr_state = 32'ha168;
    rv_pkg::word_t prog [NUM_INSTR];
    int            prog_len = 0;
    rv_pkg::word_t model_regs [32];
    rv_pkg::addr_t model_pc = BOOT_ADDR;
    rv_pkg::addr_t exp_store_addr [$];
    rv_pkg::word_t exp_store_data [$];
    int            fetched = 0;
    int            cycles = 0;

    // memory responder state
    int            igap = -1;
    int            dgap = -1;
    int            vgap = 0;
    logic          vpending = 1'b0;
    rv_pkg::word_t vword = '0;

    rv_core u_dut (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .boot_addr_i    ( boot_addr_i    ),
        .core_busy_o    ( core_busy_o    ),
        .instr_req_o    ( instr_req_o    ),
        .instr_addr_o   ( instr_addr_o   ),
        .instr_gnt_i    ( instr_gnt_i    ),
        .instr_rvalid_i ( instr_rvalid_i ),
        .instr_rdata_i  ( instr_rdata_i  ),
        .data_req_o     ( data_req_o     ),
        .data_addr_o    ( data_addr_o    ),
        .data_wdata_o   ( data_wdata_o   ),
        .data_gnt_i     ( data_gnt_i     )
    );

    always #20 clk_i = ~clk_i;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_fetch(input rv_pkg::addr_t got, input rv_pkg::addr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: fetch address %h, expected %h", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_store(input rv_pkg::addr_t got_addr, input rv_pkg::word_t got_data,
                               input rv_pkg::addr_t exp_addr, input rv_pkg::word_t exp_data);
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            $display("FAILED at %0t ns: store %h <- %h, expected %h <- %h",
                     $time, got_addr, got_data, exp_addr, exp_data);
            stop_with_failure();
        end
    endtask

    task automatic check_idle(input logic ireq, input logic dreq, input logic busy);
        if (ireq !== 1'b0 || dreq !== 1'b0 || busy !== 1'b0) begin
            $display("FAILED at %0t ns: core not idle, instr_req %b data_req %b busy %b",
                     $time, ireq, dreq, busy);
            stop_with_failure();
        end
    endtask

    task automatic check_busy(input logic busy);
        if (busy !== 1'b1) begin
            $display("FAILED at %0t ns: core_busy_o low while a request is pending", $time);
            stop_with_failure();
        end
    endtask

    // ISA reference, no timing
    task automatic run_model(input rv_pkg::word_t w);
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t res;
        logic          wr;
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        res = '0;
        wr  = 1'b0;
        if (w[6:0] == rv_pkg::OPC_OP && w[31:25] == 7'b0) begin
            wr = 1'b1;
            case (w[14:12])
                rv_pkg::F3_ADD_SUB: res = a + b;
                rv_pkg::F3_XOR:     res = a ^ b;
                rv_pkg::F3_OR:      res = a | b;
                rv_pkg::F3_AND:     res = a & b;
                default:            wr = 1'b0;
            endcase
        end else if (w[6:0] == rv_pkg::OPC_OP && w[31:25] == rv_pkg::F7_SUB
                     && w[14:12] == rv_pkg::F3_ADD_SUB) begin
            res = a - b;
            wr  = 1'b1;
        end else if (w[6:0] == rv_pkg::OPC_OP_IMM && w[14:12] == rv_pkg::F3_ADD_SUB) begin
            res = a + {{20{w[31]}}, w[31:20]};
            wr  = 1'b1;
        end else if (w[6:0] == rv_pkg::OPC_LUI) begin
            res = {w[31:12], 12'b0};
            wr  = 1'b1;
        end else if (w[6:0] == rv_pkg::OPC_STORE && w[14:12] == rv_pkg::F3_SW) begin
            exp_store_addr.push_back(a + {{20{w[31]}}, w[31:25], w[11:7]});
            exp_store_data.push_back(b);
        end
        if (wr && w[11:7] != 5'd0) begin
            model_regs[w[11:7]] = res;
        end
    endtask

    task automatic append_instr(input rv_pkg::word_t w);
        prog[prog_len] = w;
        run_model(w);
        prog_len = prog_len + 1;
    endtask

    task automatic build_program();
        logic [31:0] k;
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] simm;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        while (prog_len < NUM_RANDOM) begin
            k = draw_bits(3);
            r = draw_bits(32);
            case (k[2:0])
                3'd0, 3'd1, 3'd2: begin
                    case (r[28:27])
                        2'd1:    f3 = rv_pkg::F3_XOR;
                        2'd2:    f3 = rv_pkg::F3_OR;
                        2'd3:    f3 = rv_pkg::F3_AND;
                        default: f3 = rv_pkg::F3_ADD_SUB;
                    endcase
                    f7 = (f3 == rv_pkg::F3_ADD_SUB && r[29]) ? rv_pkg::F7_SUB : 7'b0;
                    append_instr({f7, r[14:10], r[9:5], f3, r[4:0], rv_pkg::OPC_OP});
                end
                3'd3: append_instr({r[26:15], r[9:5], rv_pkg::F3_ADD_SUB, r[4:0],
                                    rv_pkg::OPC_OP_IMM});
                3'd4: append_instr({r[31:12], r[4:0], rv_pkg::OPC_LUI});
                3'd5, 3'd6: begin
                    // base loaded by lui first so the address stays word aligned
                    if (prog_len < NUM_RANDOM - 1) begin
                        simm = {r[26:17], 2'b00};
                        append_instr({r[31:12], r[9:5], rv_pkg::OPC_LUI});
                        append_instr({simm[11:5], r[14:10], r[9:5], rv_pkg::F3_SW,
                                      simm[4:0], rv_pkg::OPC_STORE});
                    end else begin
                        append_instr({r[31:12], r[4:0], rv_pkg::OPC_LUI});
                    end
                end
                default: append_instr({r[31:7], 7'b1110011});
            endcase
        end
        // dump every register to address 4*i
        for (int i = 0; i < 32; i++) begin
            simm = 12'(i * 4);
            append_instr({simm[11:5], 5'(i), 5'd0, rv_pkg::F3_SW, simm[4:0],
                          rv_pkg::OPC_STORE});
        end
    endtask

    task automatic wait_fetched(input int n);
        while (fetched < n) begin
            @(posedge clk_i);
        end
    endtask

    task automatic wait_idle();
        @(posedge clk_i);
        while (core_busy_o) begin
            @(posedge clk_i);
        end
    endtask

    // instruction and data memory responders
    always @(posedge clk_i) begin
        logic [31:0] r;
        if (reset_i) begin
            instr_gnt_i    <= 1'b0;
            instr_rvalid_i <= 1'b0;
            data_gnt_i     <= 1'b0;
        end else begin
            instr_rvalid_i <= 1'b0;
            if (instr_req_o || data_req_o) begin
                check_busy(core_busy_o);
            end
            if (instr_req_o) begin
                if (fetched >= NUM_INSTR) begin
                    $display("fetch request past the end of the program at %h", instr_addr_o);
                    stop_with_failure();
                end
                // checked on every waiting cycle, so address must hold
                check_fetch(instr_addr_o, model_pc);
                if (instr_gnt_i) begin
                    instr_gnt_i <= 1'b0;
                    igap      = -1;
                    model_pc <= model_pc + 32'd4;
                    fetched  <= fetched + 1;
                    vword     = prog[fetched];
                    r         = draw_bits(2);
                    vgap      = int'(r[1:0]);
                    vpending  = 1'b1;
                end else begin
                    if (igap < 0) begin
                        r    = draw_bits(2);
                        igap = int'(r[1:0]);
                    end
                    if (igap == 0) begin
                        instr_gnt_i <= 1'b1;
                    end else begin
                        igap = igap - 1;
                    end
                end
            end
            if (vpending) begin
                if (vgap == 0) begin
                    instr_rvalid_i <= 1'b1;
                    instr_rdata_i  <= vword;
                    vpending = 1'b0;
                end else begin
                    vgap = vgap - 1;
                end
            end
            if (data_req_o) begin
                if (exp_store_addr.size() == 0) begin
                    $display("store request to %h when no store was expected", data_addr_o);
                    stop_with_failure();
                end else begin
                    check_store(data_addr_o, data_wdata_o, exp_store_addr[0], exp_store_data[0]);
                    if (data_gnt_i) begin
                        data_gnt_i <= 1'b0;
                        dgap = -1;
                        exp_store_addr.delete(0);
                        exp_store_data.delete(0);
                    end else begin
                        if (dgap < 0) begin
                            r    = draw_bits(2);
                            dgap = int'(r[1:0]);
                        end
                        if (dgap == 0) begin
                            data_gnt_i <= 1'b1;
                        end else begin
                            dgap = dgap - 1;
                        end
                    end
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: program of %0d instructions not done after %0d cycles",
                     NUM_INSTR, cycles);
            stop_with_failure();
        end
    end

    initial begin
        reset_i        = 1'b1;
        fetch_enable_i = 1'b0;
        boot_addr_i    = BOOT_ADDR;
        build_program();
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        // nothing may move while fetch is disabled
        repeat (4) begin
            @(posedge clk_i);
            check_idle(instr_req_o, data_req_o, core_busy_o);
        end
        fetch_enable_i <= 1'b1;
        wait_fetched(PAUSE_AT);
        fetch_enable_i <= 1'b0;
        wait_idle();
        repeat (6) begin
            @(posedge clk_i);
            check_idle(instr_req_o, data_req_o, core_busy_o);
        end
        fetch_enable_i <= 1'b1;
        wait_fetched(NUM_INSTR);
        fetch_enable_i <= 1'b0;
        wait_idle();
        if (exp_store_addr.size() != 0) begin
            $display("run ended with %0d expected stores never seen", exp_store_addr.size());
            stop_with_failure();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- src.f
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_core.sv
dv/core_tb.sv

//--- Makefile
# Verilator build and run for the rv core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= src.f
OUT_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OUT_DIR) -o V$(TOP)
	./$(OUT_DIR)/V$(TOP)

clean:
	rm -rf $(OUT_DIR)
